// File: src/ibtb_pkg.sv
package ibtb_pkg;

	// --------------------
	// field types

	// fetch or target address, low always-zero bit dropped
	typedef logic [37:0] pc38_t;

	// global history of indirect branch outcomes
	typedef logic [8:0] ibtb_gh_t;

	// address-space id, kept in full in every entry
	typedef logic [8:0] asid_t;

	// --------------------
	// controller states

	// IDLE normal operation, FLUSH walking the sets
	typedef enum logic {
		IDLE,
		FLUSH
	} ctrl_state_t;

	// --------------------
	// apb register map

	typedef enum logic [7:0] {
		REG_CTRL    = 8'h00, // bit 0 enable rw, bit 1 busy ro
		REG_FLUSH   = 8'h04, // any write starts a flush
		REG_HITS    = 8'h08, // hit counter, ro
		REG_UPDATES = 8'h0C  // accepted update counter, ro
	} apb_reg_t;

	// --------------------
	// default sizes

	// 32 sets by default
	localparam int DEF_INDEX_BITS = 5;

	// pc bits kept above the index
	localparam int DEF_TAG_BITS = 10;

	// statistics counter width
	localparam int CNT_BITS = 32;

endpackage

// File: src/ibtb_hash.sv
`timescale 1ns/1ps

module ibtb_hash import ibtb_pkg::*; #(
	parameter int INDEX_BITS = DEF_INDEX_BITS,
	parameter int TAG_BITS = DEF_TAG_BITS
) (
	input pc38_t pc,
	input ibtb_gh_t gh,

	output logic [INDEX_BITS-1:0] index,
	output logic [TAG_BITS-1:0] tag
);

	// --------------------
	// history folding

	// history width and number of index-wide chunks
	localparam int GH_BITS = $bits(ibtb_gh_t);
	localparam int NCHUNK = (GH_BITS + INDEX_BITS - 1) / INDEX_BITS;
	localparam int PAD_BITS = NCHUNK * INDEX_BITS;

	// top chunk zero padded by the cast
	logic [PAD_BITS-1:0] gh_pad;
	logic [INDEX_BITS-1:0] gh_fold;

	assign gh_pad = PAD_BITS'(gh);

	// xor all chunks down to one
	always_comb begin
		gh_fold = '0;
		for (int i = 0; i < NCHUNK; i++) begin
			gh_fold = gh_fold ^ gh_pad[i*INDEX_BITS +: INDEX_BITS];
		end
	end

	// --------------------
	// index and tag

	// low pc bits mixed with folded history
	assign index = pc[INDEX_BITS-1:0] ^ gh_fold;

	// tag taken straight from the bits above the index
	assign tag = pc[INDEX_BITS +: TAG_BITS];

	// read and update paths share this block
	// so both always land on the same set

endmodule

// File: src/ibtb.sv
`timescale 1ns/1ps

module ibtb import ibtb_pkg::*; #(
	parameter int INDEX_BITS = DEF_INDEX_BITS,
	parameter int TAG_BITS = DEF_TAG_BITS
) (
	input logic CLK,
	input logic nRST,

	// lookup
	input logic [INDEX_BITS-1:0] read_index,
	input logic [TAG_BITS-1:0] read_tag,
	input asid_t read_asid,
	input logic lookup_enable,
	output logic read_hit,
	output pc38_t read_tgt_pc38,

	// training
	input logic update_valid,
	input logic update_enable,
	input logic [INDEX_BITS-1:0] update_index,
	input logic [TAG_BITS-1:0] update_tag,
	input asid_t update_asid,
	input pc38_t update_tgt_pc38,

	// flush walk
	input logic clear_valid,
	input logic [INDEX_BITS-1:0] clear_index
);

	localparam int SETS = 2 ** INDEX_BITS;

	// --------------------
	// storage

	// per set: valid per way, lru names the way to replace
	logic [1:0] valid_q [SETS];
	logic [SETS-1:0] lru_q;

	// payload per way
	logic [TAG_BITS-1:0] tag_q [SETS][2];
	asid_t asid_q [SETS][2];
	pc38_t tgt_q [SETS][2];

	// --------------------
	// lookup

	logic [1:0] rd_match;

	// valid way with both tag and asid equal
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			rd_match[w] = valid_q[read_index][w]
				&& (tag_q[read_index][w] == read_tag)
				&& (asid_q[read_index][w] == read_asid);
		end
	end

	// disabled lookup or no match gives a clean miss
	always_comb begin
		read_hit = 1'b0;
		read_tgt_pc38 = '0;
		if (lookup_enable) begin
			if (rd_match[0]) begin
				read_hit = 1'b1;
				read_tgt_pc38 = tgt_q[read_index][0];
			end
			else if (rd_match[1]) begin
				read_hit = 1'b1;
				read_tgt_pc38 = tgt_q[read_index][1];
			end
		end
	end

	// --------------------
	// update way select

	logic upd_fire;
	logic [1:0] upd_match;
	logic upd_way;

	assign upd_fire = update_valid && update_enable;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			upd_match[w] = valid_q[update_index][w]
				&& (tag_q[update_index][w] == update_tag)
				&& (asid_q[update_index][w] == update_asid);
		end
	end

	// matching way, then first free way, then lru victim
	always_comb begin
		if (upd_match[0])
			upd_way = 1'b0;
		else if (upd_match[1])
			upd_way = 1'b1;
		else if (!valid_q[update_index][0])
			upd_way = 1'b0;
		else if (!valid_q[update_index][1])
			upd_way = 1'b1;
		else
			upd_way = lru_q[update_index];
	end

	// --------------------
	// state update

	// clear wins, though the controller never overlaps the two
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= 2'b00;
			end
			lru_q <= '0;
		end
		else if (clear_valid) begin
			valid_q[clear_index] <= 2'b00;
			lru_q[clear_index] <= 1'b0;
		end
		else if (upd_fire) begin
			valid_q[update_index][upd_way] <= 1'b1;
			// other way is now the victim
			lru_q[update_index] <= ~upd_way;
		end
	end

	// tag, asid and target written with the valid bit
	always_ff @(posedge CLK) begin
		if (upd_fire && !clear_valid) begin
			tag_q[update_index][upd_way] <= update_tag;
			asid_q[update_index][upd_way] <= update_asid;
			tgt_q[update_index][upd_way] <= update_tgt_pc38;
		end
	end

	// --------------------
	// checks

	logic [SETS-1:0] dup_set;

	always_comb begin
		for (int s = 0; s < SETS; s++) begin
			dup_set[s] = valid_q[s][0] && valid_q[s][1]
				&& (tag_q[s][0] == tag_q[s][1])
				&& (asid_q[s][0] == asid_q[s][1]);
		end
	end

	// a training write never leaves the same entry in both ways
	a_no_dup_entry: assert property (@(posedge CLK) disable iff (!nRST)
		(upd_fire && !clear_valid) |=> !dup_set[$past(update_index)]);

endmodule

// File: src/ibtb_ctrl.sv
`timescale 1ns/1ps

module ibtb_ctrl import ibtb_pkg::*; #(
	parameter int INDEX_BITS = DEF_INDEX_BITS
) (
	input logic CLK,
	input logic nRST,

	// apb slave
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input logic [7:0] PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,

	// events from the core path
	input logic read_hit,
	input logic update_valid,

	// core control
	output logic lookup_enable,
	output logic update_enable,
	output logic clear_valid,
	output logic [INDEX_BITS-1:0] clear_index
);

	// --------------------
	// apb decode

	logic access;
	logic wr_en;
	logic addr_ok;
	logic ro_reg;
	apb_reg_t reg_sel;

	// no wait states
	assign PREADY = 1'b1;

	assign access = PSEL && PENABLE;
	assign reg_sel = apb_reg_t'(PADDR);
	assign addr_ok = PADDR inside {REG_CTRL, REG_FLUSH, REG_HITS, REG_UPDATES};
	assign ro_reg = (reg_sel == REG_HITS) || (reg_sel == REG_UPDATES);

	// bad address or write to a counter
	assign PSLVERR = access && (!addr_ok || (PWRITE && ro_reg));

	// write lands at the edge ending the access phase
	assign wr_en = access && PWRITE && !PSLVERR;

	// --------------------
	// control and flush fsm

	ctrl_state_t state_q;
	logic enable_q;
	logic busy;
	logic [CNT_BITS-1:0] hit_cnt_q;
	logic [CNT_BITS-1:0] upd_cnt_q;

	assign busy = (state_q == FLUSH);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state_q <= IDLE;
			enable_q <= 1'b0;
			clear_index <= '0;
		end
		else begin
			if (wr_en && reg_sel == REG_CTRL)
				enable_q <= PWDATA[0];
			case (state_q)
				IDLE: begin
					// request while busy falls through to FLUSH arm
					if (wr_en && reg_sel == REG_FLUSH) begin
						state_q <= FLUSH;
						clear_index <= '0;
					end
				end
				FLUSH: begin
					// one set per cycle until the last set
					clear_index <= clear_index + 1'b1;
					if (clear_index == '1)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	assign clear_valid = busy;

	// core runs only when enabled and not flushing
	assign lookup_enable = enable_q && !busy;
	assign update_enable = enable_q && !busy;

	// --------------------
	// statistics

	// both counters stick at all ones
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			hit_cnt_q <= '0;
			upd_cnt_q <= '0;
		end
		else begin
			if (read_hit && hit_cnt_q != '1)
				hit_cnt_q <= hit_cnt_q + 1'b1;
			if (update_valid && update_enable && upd_cnt_q != '1)
				upd_cnt_q <= upd_cnt_q + 1'b1;
		end
	end

	// --------------------
	// read data

	always_comb begin
		PRDATA = '0;
		if (access && !PWRITE) begin
			case (reg_sel)
				REG_CTRL:    PRDATA = {30'b0, busy, enable_q};
				REG_HITS:    PRDATA = hit_cnt_q;
				REG_UPDATES: PRDATA = upd_cnt_q;
				default:     PRDATA = '0;
			endcase
		end
	end

	// --------------------
	// checks

	// access phase only after a setup phase
	a_penable_psel: assert property (@(posedge CLK) disable iff (!nRST)
		PENABLE |-> PSEL);

	// flush walk ends only after the last set was cleared
	a_flush_walk_end: assert property (@(posedge CLK) disable iff (!nRST)
		$fell(clear_valid) |-> $past(clear_index) == '1);

endmodule

// File: src/ibtb_top.sv
`timescale 1ns/1ps

module ibtb_top import ibtb_pkg::*; #(
	parameter int INDEX_BITS = DEF_INDEX_BITS,
	parameter int TAG_BITS = DEF_TAG_BITS
) (
	input logic CLK,
	input logic nRST,

	// read
	input pc38_t next_read_src_pc38,
	input ibtb_gh_t next_read_ibtb_gh,
	input asid_t next_read_asid,
	output pc38_t last_read_tgt_pc38,
	output logic last_read_hit,

	// update
	input logic next_update_valid,
	input pc38_t next_update_src_pc38,
	input ibtb_gh_t next_update_ibtb_gh,
	input asid_t next_update_asid,
	input pc38_t next_update_tgt_pc38,

	// apb
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input logic [7:0] PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR
);

	// --------------------
	// internal nets

	// registered read request and core result
	pc38_t read_src_pc38;
	ibtb_gh_t read_ibtb_gh;
	asid_t read_asid;
	logic [INDEX_BITS-1:0] read_index;
	logic [TAG_BITS-1:0] read_tag;
	logic read_hit;
	pc38_t read_tgt_pc38;

	// registered update request
	logic update_valid;
	pc38_t update_src_pc38;
	ibtb_gh_t update_ibtb_gh;
	asid_t update_asid;
	pc38_t update_tgt_pc38;
	logic [INDEX_BITS-1:0] update_index;
	logic [TAG_BITS-1:0] update_tag;

	// controller to core
	logic lookup_enable;
	logic update_enable;
	logic clear_valid;
	logic [INDEX_BITS-1:0] clear_index;

	// --------------------
	// instances

	// same hash on both paths
	ibtb_hash #(.INDEX_BITS(INDEX_BITS), .TAG_BITS(TAG_BITS)) u_read_hash (
		.pc(read_src_pc38), .gh(read_ibtb_gh), .index(read_index), .tag(read_tag)
	);

	ibtb_hash #(.INDEX_BITS(INDEX_BITS), .TAG_BITS(TAG_BITS)) u_update_hash (
		.pc(update_src_pc38), .gh(update_ibtb_gh), .index(update_index), .tag(update_tag)
	);

	ibtb #(.INDEX_BITS(INDEX_BITS), .TAG_BITS(TAG_BITS)) u_core (.*);

	ibtb_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (.*);

	// --------------------
	// wrapper registers

	// core only ever sees registered inputs
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			read_src_pc38 <= '0;
			read_ibtb_gh <= '0;
			read_asid <= '0;
			last_read_hit <= 1'b0;
			last_read_tgt_pc38 <= '0;
			update_valid <= 1'b0;
			update_src_pc38 <= '0;
			update_ibtb_gh <= '0;
			update_asid <= '0;
			update_tgt_pc38 <= '0;
		end
		else begin
			read_src_pc38 <= next_read_src_pc38;
			read_ibtb_gh <= next_read_ibtb_gh;
			read_asid <= next_read_asid;
			// second edge of the read latency
			last_read_hit <= read_hit;
			last_read_tgt_pc38 <= read_tgt_pc38;
			update_valid <= next_update_valid;
			update_src_pc38 <= next_update_src_pc38;
			update_ibtb_gh <= next_update_ibtb_gh;
			update_asid <= next_update_asid;
			update_tgt_pc38 <= next_update_tgt_pc38;
		end
	end

	// --------------------
	// checks

	// a registered hit needs the controller enable in the lookup cycle
	a_hit_needs_enable: assert property (@(posedge CLK) disable iff (!nRST)
		last_read_hit |-> $past(lookup_enable));

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic nRST
);

	// 4 ns period
	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// reset held for 10 cycles, released on an edge
	initial begin
		nRST = 1'b0;
		repeat (10) @(posedge CLK);
		nRST <= 1'b1;
	end

endmodule

// File: tb/ibtb_tb.sv
`timescale 1ns/1ps

module ibtb_tb import ibtb_pkg::*; ();

	localparam int IDX = DEF_INDEX_BITS;
	localparam int TAGW = DEF_TAG_BITS;
	localparam int SETS = 1 << IDX;
	localparam int LIMIT = 200;

	logic CLK, nRST;
	pc38_t next_read_src_pc38, next_update_src_pc38, next_update_tgt_pc38, last_read_tgt_pc38;
	ibtb_gh_t next_read_ibtb_gh, next_update_ibtb_gh;
	asid_t next_read_asid, next_update_asid;
	logic next_update_valid, last_read_hit;
	logic PSEL, PENABLE, PWRITE, PREADY, PSLVERR;
	logic [7:0] PADDR;
	logic [31:0] PWDATA, PRDATA;
	int fail_count = 0;

	tb_clock u_clock (.CLK(CLK), .nRST(nRST));
	ibtb_top UUT (.*);

	// --------------------
	// reference model

	logic m_valid [SETS][2];
	logic [TAGW-1:0] m_tag [SETS][2];
	asid_t m_asid [SETS][2];
	pc38_t m_tgt [SETS][2];
	logic m_lru [SETS];
	logic m_en, m_busy, exp_hit, exp_err;
	logic [IDX-1:0] m_fidx;
	logic [31:0] m_hits, m_upds, exp_prdata;
	pc38_t exp_tgt, rr_pc, ru_pc, ru_tgt;
	ibtb_gh_t rr_gh, ru_gh;
	asid_t rr_asid, ru_asid;
	logic ru_valid;

	// history folded bit by bit onto the index, then mixed with low pc bits
	function automatic logic [IDX-1:0] set_of(pc38_t pc, ibtb_gh_t gh);
		logic [IDX-1:0] f;
		f = '0;
		for (int i = 0; i < $bits(ibtb_gh_t); i++)
			f[i % IDX] = f[i % IDX] ^ gh[i];
		return pc[IDX-1:0] ^ f;
	endfunction

	function automatic logic [TAGW-1:0] tag_of(pc38_t pc);
		return pc[IDX +: TAGW];
	endfunction

	// match, then free way 0, free way 1, then lru victim
	function automatic int pick_way(logic [IDX-1:0] s, logic [TAGW-1:0] t, asid_t a);
		for (int w = 0; w < 2; w++)
			if (m_valid[s][w] && m_tag[s][w] == t && m_asid[s][w] == a)
				return w;
		if (!m_valid[s][0])
			return 0;
		if (!m_valid[s][1])
			return 1;
		return m_lru[s] ? 1 : 0;
	endfunction

	always @(posedge CLK or negedge nRST) begin : ref_model
		logic le, was_busy, hit;
		logic [IDX-1:0] s;
		logic [TAGW-1:0] t;
		pc38_t tgt;
		int w;
		if (!nRST) begin
			for (int i = 0; i < SETS; i++) begin
				m_valid[i][0] = 1'b0;
				m_valid[i][1] = 1'b0;
				m_lru[i] = 1'b0;
			end
			{m_en, m_busy, exp_hit, ru_valid} = '0;
			{m_fidx, m_hits, m_upds, exp_tgt} = '0;
			{rr_pc, rr_gh, rr_asid, ru_pc, ru_gh, ru_asid, ru_tgt} = '0;
		end
		else begin
			// enables as seen during the cycle that ends here
			was_busy = m_busy;
			le = m_en && !m_busy;
			// lookup of the request registered one edge ago
			s = set_of(rr_pc, rr_gh);
			t = tag_of(rr_pc);
			hit = 1'b0;
			tgt = '0;
			for (int i = 0; i < 2; i++)
				if (le && !hit && m_valid[s][i] && m_tag[s][i] == t
					&& m_asid[s][i] == rr_asid) begin
					hit = 1'b1;
					tgt = m_tgt[s][i];
				end
			exp_hit = hit;
			exp_tgt = tgt;
			if (hit && m_hits != '1)
				m_hits = m_hits + 1;
			// training write lands one edge after registering
			if (ru_valid && le) begin
				s = set_of(ru_pc, ru_gh);
				t = tag_of(ru_pc);
				w = pick_way(s, t, ru_asid);
				m_valid[s][w] = 1'b1;
				m_tag[s][w] = t;
				m_asid[s][w] = ru_asid;
				m_tgt[s][w] = ru_tgt;
				m_lru[s] = (w == 0);
				if (m_upds != '1)
					m_upds = m_upds + 1;
			end
			// one set cleared per edge
			if (was_busy) begin
				m_valid[m_fidx][0] = 1'b0;
				m_valid[m_fidx][1] = 1'b0;
				m_lru[m_fidx] = 1'b0;
				if (m_fidx == IDX'(SETS - 1))
					m_busy = 1'b0;
				m_fidx = m_fidx + 1'b1;
			end
			// apb write completing at this edge
			if (PSEL && PENABLE && PWRITE) begin
				if (PADDR == 8'h00)
					m_en = PWDATA[0];
				else if (PADDR == 8'h04 && !was_busy) begin
					m_busy = 1'b1;
					m_fidx = '0;
				end
			end
			rr_pc = next_read_src_pc38;
			rr_gh = next_read_ibtb_gh;
			rr_asid = next_read_asid;
			ru_valid = next_update_valid;
			ru_pc = next_update_src_pc38;
			ru_gh = next_update_ibtb_gh;
			ru_asid = next_update_asid;
			ru_tgt = next_update_tgt_pc38;
		end
	end

	// expected apb responses from the register map
	always_comb begin
		exp_prdata = '0;
		if (PSEL && PENABLE && !PWRITE)
			case (PADDR)
				8'h00: exp_prdata = {30'b0, m_busy, m_en};
				8'h08: exp_prdata = m_hits;
				8'h0C: exp_prdata = m_upds;
				default: exp_prdata = '0;
			endcase
		exp_err = PSEL && PENABLE && (!(PADDR inside {8'h00, 8'h04, 8'h08, 8'h0C})
			|| (PWRITE && (PADDR == 8'h08 || PADDR == 8'h0C)));
	end

	// --------------------
	// checks

	task automatic report_failure(string msg);
		fail_count++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("Checks failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic abort_run(string msg);
		fail_count++;
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "stopping on timeout");
	endtask

	a_hit: assert property (@(posedge CLK) disable iff (!nRST) last_read_hit == exp_hit)
		else report_failure("last_read_hit differs from model");
	a_tgt: assert property (@(posedge CLK) disable iff (!nRST) last_read_tgt_pc38 == exp_tgt)
		else report_failure("last_read_tgt_pc38 differs from model");
	a_prdata: assert property (@(posedge CLK) disable iff (!nRST)
		(PSEL && PENABLE && !PWRITE) |-> PRDATA == exp_prdata)
		else report_failure("PRDATA differs from model");
	a_pslverr: assert property (@(posedge CLK) disable iff (!nRST) PSLVERR == exp_err)
		else report_failure("PSLVERR differs from model");
	a_pready: assert property (@(posedge CLK) disable iff (!nRST) PREADY)
		else report_failure("PREADY low");

	// --------------------
	// stimulus helpers

	// advance one edge and drop the update strobe unless re-presented
	task automatic tick();
		@(posedge CLK);
		next_update_valid <= 1'b0;
	endtask

	task automatic present_read(pc38_t pc, ibtb_gh_t gh, asid_t a);
		next_read_src_pc38 <= pc;
		next_read_ibtb_gh <= gh;
		next_read_asid <= a;
	endtask

	task automatic present_update(pc38_t pc, ibtb_gh_t gh, asid_t a, pc38_t tgt);
		next_update_valid <= 1'b1;
		next_update_src_pc38 <= pc;
		next_update_ibtb_gh <= gh;
		next_update_asid <= a;
		next_update_tgt_pc38 <= tgt;
	endtask

	task automatic apb_write(logic [7:0] addr, logic [31:0] data);
		tick();
		PSEL <= 1'b1;
		PWRITE <= 1'b1;
		PADDR <= addr;
		PWDATA <= data;
		tick();
		PENABLE <= 1'b1;
		tick();
		{PSEL, PENABLE, PWRITE} <= 3'b000;
	endtask

	// data taken mid access phase
	task automatic apb_read(logic [7:0] addr, output logic [31:0] data);
		tick();
		PSEL <= 1'b1;
		PWRITE <= 1'b0;
		PADDR <= addr;
		tick();
		PENABLE <= 1'b1;
		#1 data = PRDATA;
		tick();
		{PSEL, PENABLE} <= 2'b00;
	endtask

	task automatic wait_flush_done();
		logic [31:0] d;
		logic done;
		done = 1'b0;
		for (int n = 0; n < LIMIT && !done; n++) begin
			apb_read(8'h00, d);
			done = !d[1];
		end
		if (!done)
			abort_run("timeout waiting for flush busy to clear");
	endtask

	function automatic pc38_t rand_pc();
		return pc38_t'({$urandom(), $urandom()});
	endfunction

	// --------------------
	// main sequence

	pc38_t tr_pc [8], tr_tgt [8];
	ibtb_gh_t tr_gh [8];
	asid_t tr_asid [8];

	initial begin
		logic [31:0] d;
		pc38_t p;
		next_read_src_pc38 = '0;
		next_read_ibtb_gh = '0;
		next_read_asid = '0;
		next_update_valid = 1'b0;
		next_update_src_pc38 = '0;
		next_update_ibtb_gh = '0;
		next_update_asid = '0;
		next_update_tgt_pc38 = '0;
		{PSEL, PENABLE, PWRITE, PADDR, PWDATA} = '0;
		void'($urandom(61409));
		for (int n = 0; n < 100 && !nRST; n++)
			@(posedge CLK);
		if (!nRST)
			abort_run("timeout waiting for reset release");

		// updates before enable are dropped
		apb_read(8'h00, d);
		tick();
		p = rand_pc();
		present_update(p, 9'h0, 9'h1, rand_pc());
		repeat (3) tick();
		apb_read(8'h0C, d);
		apb_write(8'h00, 32'h1);
		// the dropped entry misses once enabled
		tick();
		present_read(p, 9'h0, 9'h1);

		// train random entries, then predict
		for (int i = 0; i < 8; i++) begin
			tr_pc[i] = rand_pc();
			tr_gh[i] = ibtb_gh_t'($urandom());
			tr_asid[i] = asid_t'($urandom());
			tr_tgt[i] = rand_pc();
			tick();
			present_update(tr_pc[i], tr_gh[i], tr_asid[i], tr_tgt[i]);
		end
		tick();
		for (int i = 0; i < 8; i++) begin
			tick();
			present_read(tr_pc[i], tr_gh[i], tr_asid[i]);
			tick();
			present_read(tr_pc[i], tr_gh[i], tr_asid[i] ^ 9'h1);
			tick();
			present_read(rand_pc(), tr_gh[i], tr_asid[i]);
		end

		// three tags into set 7, then retrain the newest
		for (int k = 1; k <= 3; k++) begin
			tick();
			present_update(pc38_t'({k[TAGW-1:0], 5'd7}), 9'h0, 9'h2, pc38_t'(k * 100));
		end
		tick();
		for (int k = 1; k <= 3; k++) begin
			tick();
			present_read(pc38_t'({k[TAGW-1:0], 5'd7}), 9'h0, 9'h2);
		end
		tick();
		present_update(pc38_t'({10'd3, 5'd7}), 9'h0, 9'h2, pc38_t'(38'h3ff));
		for (int k = 1; k <= 3; k++) begin
			tick();
			present_read(pc38_t'({k[TAGW-1:0], 5'd7}), 9'h0, 9'h2);
		end

		// same cycle read sees the old target and the next one the new
		p = tr_pc[0];
		tick();
		present_update(p, tr_gh[0], tr_asid[0], ~tr_tgt[0]);
		present_read(p, tr_gh[0], tr_asid[0]);
		tick();
		present_read(p, tr_gh[0], tr_asid[0]);
		repeat (3) tick();

		// flush with traffic in flight
		apb_write(8'h04, 32'h0);
		for (int i = 0; i < 4; i++) begin
			tick();
			present_update(rand_pc(), tr_gh[i], tr_asid[i], rand_pc());
			present_read(tr_pc[i], tr_gh[i], tr_asid[i]);
		end
		apb_write(8'h04, 32'h0);
		wait_flush_done();
		for (int i = 0; i < 8; i++) begin
			tick();
			present_read(tr_pc[i], tr_gh[i], tr_asid[i]);
		end

		// counters and error responses
		apb_read(8'h08, d);
		apb_read(8'h0C, d);
		apb_write(8'h08, 32'h5);
		apb_read(8'h10, d);
		apb_write(8'h14, 32'h1);
		apb_read(8'h08, d);
		repeat (4) tick();

		if (fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: ibtb_top.f
src/ibtb_pkg.sv
src/ibtb_hash.sv
src/ibtb.sv
src/ibtb_ctrl.sv
src/ibtb_top.sv
tb/tb_clock.sv
tb/ibtb_tb.sv

// File: run.sh
#!/bin/sh
# build and run the ibtb testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f ibtb_top.f \
	--top-module ibtb_tb \
	--Mdir obj_dir \
	-o ibtb_sim

# a fatal stop returns nonzero, the log decides the result
./obj_dir/ibtb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
